/* Makefile */
# Verilator simulation of the SpaceWire receiver

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, look for the pass message in $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
		--top-module tb_spw_rx -Mdir obj_dir -f compile.f
	./obj_dir/Vtb_spw_rx | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* compile.f */
rtl/spw_char_pkg.sv
rtl/spw_rx_status_pkg.sv
rtl/spw_ds_decoder.sv
rtl/spw_char_assembler.sv
rtl/spw_rx_control.sv
rtl/spw_code_decoder.sv
rtl/spw_rx_top.sv
verif/spw_rx_checker.sv
verif/tb_spw_rx.sv

/* rtl/spw_char_assembler.sv */
// Character shift register, running payload parity and parity check against the flag bit

`timescale 1ns/10ps

module spw_char_assembler (
	input  logic                   negedge_clk,
	input  logic                   rx_resetn,
	input  logic                   bit_valid,
	input  logic                   bit_value,
	input  logic                   char_start,
	output spw_char_pkg::spw_char_u char_word,
	output logic                   parity_ok
);

	localparam int pos_width = $clog2(spw_char_pkg::char_width);

	logic [spw_char_pkg::char_width-1:0] word_q;
	logic [pos_width-1:0]                pos;
	logic                                run_xor;
	logic                                prev_parity;

	assign char_word = word_q;

	// Previous payload, parity bit and flag must sum odd
	assign parity_ok = prev_parity ^ word_q[0] ^ bit_value;

	// Position and parity bookkeeping
	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			pos         <= '0;
			run_xor     <= 1'b0;
			prev_parity <= 1'b0;
		end
		else if (bit_valid)
		begin
			if (char_start)
			begin
				prev_parity <= run_xor;
				run_xor     <= 1'b0;
				pos         <= pos_width'(1);
			end
			else if (pos < pos_width'(spw_char_pkg::char_width))
			begin
				// Payload starts after parity and flag
				if (pos >= pos_width'(2))
					run_xor <= run_xor ^ bit_value;
				pos <= pos + 1'b1;
			end
		end
	end

	// Character bits, first bit at bit 0
	always_ff @(posedge negedge_clk)
	begin
		if (bit_valid)
		begin
			if (char_start)
				word_q <= {{(spw_char_pkg::char_width-1){1'b0}}, bit_value};
			else if (pos < pos_width'(spw_char_pkg::char_width))
				word_q[pos] <= bit_value;
		end
	end

endmodule

/* rtl/spw_char_pkg.sv */
// Character format: field widths, control codes, buffer flag words and the character union

package spw_char_pkg;

	// Bits per character, parity and flag included
	localparam int char_width = 10;
	localparam int ctrl_width = 4;

	// Control codes, first received code bit as LSB
	localparam logic [1:0] code_fct = 2'd0;
	localparam logic [1:0] code_eop = 2'd1;
	localparam logic [1:0] code_eep = 2'd2;
	localparam logic [1:0] code_esc = 2'd3;

	// Receive buffer words for packet ends
	localparam logic [8:0] flag_eop = 9'd256;
	localparam logic [8:0] flag_eep = 9'd257;

	// ----------------------------------------
	// Bit 0 is the first bit on the wire
	// ----------------------------------------
	typedef struct packed {
		logic [7:0] data;
		logic       flag;
		logic       parity;
	} spw_data_view_t;

	typedef struct packed {
		logic [5:0] unused;
		logic [1:0] code;
		logic       flag;
		logic       parity;
	} spw_ctrl_view_t;

	typedef union packed {
		spw_data_view_t data;
		spw_ctrl_view_t ctrl;
	} spw_char_u;

endpackage

/* rtl/spw_code_decoder.sv */
// Escape tracking and decoding of finished characters into strobes, buffer words and time codes

`timescale 1ns/10ps

module spw_code_decoder (
	input  logic                    negedge_clk,
	input  logic                    rx_resetn,
	input  logic                    char_done,
	input  logic                    is_control,
	input  logic                    halt,
	input  spw_char_pkg::spw_char_u char_word,
	output logic                    rx_got_fct,
	output logic                    rx_got_null,
	output logic                    rx_got_nchar,
	output logic                    rx_got_time_code,
	output logic [8:0]              rx_data_flag,
	output logic                    rx_buffer_write,
	output logic [7:0]              rx_time_out,
	output logic                    rx_tick_out,
	output logic                    esc_error
);

	logic       esc_pending;
	logic       take;
	logic [1:0] code;

	assign take = char_done && !halt;
	assign code = char_word.ctrl.code;

	// ----------------------------------------
	// Strobes and escape state
	// ----------------------------------------
	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			esc_pending      <= 1'b0;
			rx_got_fct       <= 1'b0;
			rx_got_null      <= 1'b0;
			rx_got_nchar     <= 1'b0;
			rx_got_time_code <= 1'b0;
			rx_buffer_write  <= 1'b0;
			rx_tick_out      <= 1'b0;
			esc_error        <= 1'b0;
		end
		else
		begin
			rx_got_fct       <= 1'b0;
			rx_got_null      <= 1'b0;
			rx_got_nchar     <= 1'b0;
			rx_got_time_code <= 1'b0;
			rx_buffer_write  <= 1'b0;
			rx_tick_out      <= 1'b0;
			esc_error        <= 1'b0;
			if (take)
			begin
				if (esc_pending)
				begin
					esc_pending <= 1'b0;
					if (!is_control)
					begin
						rx_got_time_code <= 1'b1;
						rx_tick_out      <= 1'b1;
					end
					else if (code == spw_char_pkg::code_fct)
						rx_got_null <= 1'b1;
					else
						esc_error <= 1'b1;
				end
				else if (!is_control)
				begin
					rx_got_nchar    <= 1'b1;
					rx_buffer_write <= 1'b1;
				end
				else
				begin
					case (code)
						spw_char_pkg::code_fct: rx_got_fct <= 1'b1;
						spw_char_pkg::code_esc: esc_pending <= 1'b1;
						default:
						begin
							// EOP and EEP go to the buffer as N-chars
							rx_got_nchar    <= 1'b1;
							rx_buffer_write <= 1'b1;
						end
					endcase
				end
			end
		end
	end

	// Payload words, valid with their strobes
	always_ff @(posedge negedge_clk)
	begin
		if (take && !is_control && esc_pending)
			rx_time_out <= char_word.data.data;
		else if (take && !is_control)
			rx_data_flag <= {1'b0, char_word.data.data};
		else if (take && !esc_pending && code == spw_char_pkg::code_eop)
			rx_data_flag <= spw_char_pkg::flag_eop;
		else if (take && !esc_pending && code == spw_char_pkg::code_eep)
			rx_data_flag <= spw_char_pkg::flag_eep;
	end

	a_one_event: assert property (@(posedge negedge_clk) disable iff (!rx_resetn)
		$onehot0({rx_got_fct, rx_got_null, rx_got_nchar, rx_got_time_code}));

endmodule

/* rtl/spw_ds_decoder.sv */
// Data-strobe input synchronizer, bit recovery on data xor strobe changes, disconnect timer

`timescale 1ns/10ps

module spw_ds_decoder #(
	parameter int disc_cycles = 32
) (
	input  logic negedge_clk,
	input  logic rx_resetn,
	input  logic rx_din,
	input  logic rx_sin,
	output logic bit_valid,
	output logic bit_value,
	output logic disconnect
);

	localparam int cnt_width = $clog2(disc_cycles + 1);

	logic [1:0]           din_sync;
	logic [1:0]           sin_sync;
	logic                 xor_prev;
	logic                 change;
	logic                 armed;
	logic [cnt_width-1:0] quiet_cnt;

	// Any edge on either line flips data xor strobe
	assign change = (din_sync[1] ^ sin_sync[1]) != xor_prev;

	// ----------------------------------------
	// Synchronizer and compare stage
	// ----------------------------------------
	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			din_sync  <= '0;
			sin_sync  <= '0;
			xor_prev  <= 1'b0;
			bit_valid <= 1'b0;
			bit_value <= 1'b0;
		end
		else
		begin
			din_sync  <= {din_sync[0], rx_din};
			sin_sync  <= {sin_sync[0], rx_sin};
			xor_prev  <= din_sync[1] ^ sin_sync[1];
			bit_valid <= change;
			bit_value <= din_sync[1];
		end
	end

	// Quiet counter, armed by the first transition
	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			armed      <= 1'b0;
			quiet_cnt  <= '0;
			disconnect <= 1'b0;
		end
		else if (change)
		begin
			armed      <= 1'b1;
			quiet_cnt  <= '0;
			disconnect <= 1'b0;
		end
		else if (armed && !disconnect)
		begin
			if (quiet_cnt == cnt_width'(disc_cycles - 1))
				disconnect <= 1'b1;
			else
				quiet_cnt <= quiet_cnt + 1'b1;
		end
	end

	// Input bit rate must stay well below the sample clock
	a_single_bit_pulse: assert property (@(posedge negedge_clk) disable iff (!rx_resetn)
		bit_valid |=> !bit_valid);

endmodule

/* rtl/spw_rx_control.sv */
// Character framing FSM, parity check timing and error latching with cause

`timescale 1ns/10ps

module spw_rx_control (
	input  logic                                     negedge_clk,
	input  logic                                     rx_resetn,
	input  logic                                     bit_valid,
	input  logic                                     bit_value,
	input  logic                                     parity_ok,
	input  logic                                     disconnect,
	input  logic                                     esc_error,
	output logic                                     char_start,
	output logic                                     char_done,
	output logic                                     is_control,
	output logic                                     halt,
	output logic                                     rx_error,
	output logic [spw_rx_status_pkg::cause_width-1:0] rx_error_cause
);

	localparam int idx_width = $clog2(spw_char_pkg::char_width);

	logic [idx_width-1:0] bit_idx;
	logic                 last_bit;
	logic                 parity_fail;
	logic                 take_bit;

	// Decoding stops for good once an error is latched
	assign halt     = rx_error;
	assign take_bit = bit_valid && !halt;

	assign char_start  = take_bit && (bit_idx == '0);
	assign parity_fail = take_bit && (bit_idx == idx_width'(1)) && !parity_ok;

	// Control characters end after 4 bits, data after 10
	assign last_bit = is_control ?
		(bit_idx == idx_width'(spw_char_pkg::ctrl_width - 1)) :
		(bit_idx == idx_width'(spw_char_pkg::char_width - 1));

	// ----------------------------------------
	// Framing
	// ----------------------------------------
	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			bit_idx    <= '0;
			is_control <= 1'b0;
			char_done  <= 1'b0;
		end
		else
		begin
			char_done <= 1'b0;
			if (take_bit)
			begin
				if (bit_idx == idx_width'(1))
				begin
					// Flag bit decides the character length
					is_control <= bit_value;
					bit_idx    <= bit_idx + 1'b1;
				end
				else if (bit_idx >= idx_width'(2) && last_bit)
				begin
					bit_idx   <= '0;
					char_done <= 1'b1;
				end
				else
					bit_idx <= bit_idx + 1'b1;
			end
		end
	end

	// First cause wins and sticks until reset
	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			rx_error       <= 1'b0;
			rx_error_cause <= spw_rx_status_pkg::err_cause_none;
		end
		else if (!rx_error)
		begin
			if (parity_fail)
			begin
				rx_error       <= 1'b1;
				rx_error_cause <= spw_rx_status_pkg::err_cause_parity;
			end
			else if (esc_error)
			begin
				rx_error       <= 1'b1;
				rx_error_cause <= spw_rx_status_pkg::err_cause_escape;
			end
			else if (disconnect)
			begin
				rx_error       <= 1'b1;
				rx_error_cause <= spw_rx_status_pkg::err_cause_disconnect;
			end
		end
	end

	a_cause_clear: assert property (@(posedge negedge_clk) disable iff (!rx_resetn)
		!rx_error |-> rx_error_cause == spw_rx_status_pkg::err_cause_none);

endmodule

/* rtl/spw_rx_status_pkg.sv */
// Receiver status: error cause width and cause codes

package spw_rx_status_pkg;

	// Width of the cause field
	localparam int cause_width = 2;

	// No error seen since reset
	localparam logic [cause_width-1:0] err_cause_none       = 2'd0;

	// Odd parity failed on a flag bit
	localparam logic [cause_width-1:0] err_cause_parity     = 2'd1;

	// ESC followed by ESC, EOP or EEP
	localparam logic [cause_width-1:0] err_cause_escape     = 2'd2;

	// Lines went quiet after traffic
	localparam logic [cause_width-1:0] err_cause_disconnect = 2'd3;

endpackage

/* rtl/spw_rx_top.sv */
// SpaceWire receiver top level: DS decoder, character assembler, framing control, code decoder

`timescale 1ns/10ps

module spw_rx_top #(
	parameter int disc_cycles = 32
) (
	input  logic                                     negedge_clk,
	input  logic                                     rx_resetn,
	input  logic                                     rx_din,
	input  logic                                     rx_sin,
	output logic                                     rx_got_bit,
	output logic                                     rx_got_fct,
	output logic                                     rx_got_null,
	output logic                                     rx_got_nchar,
	output logic                                     rx_got_time_code,
	output logic [8:0]                               rx_data_flag,
	output logic                                     rx_buffer_write,
	output logic [7:0]                               rx_time_out,
	output logic                                     rx_tick_out,
	output logic                                     rx_error,
	output logic [spw_rx_status_pkg::cause_width-1:0] rx_error_cause,
	output logic                                     rx_disconnect
);

	logic                    bit_valid;
	logic                    bit_value;
	logic                    char_start;
	logic                    char_done;
	logic                    parity_ok;
	logic                    is_control;
	logic                    halt;
	logic                    esc_error;
	spw_char_pkg::spw_char_u char_word;

	assign rx_got_bit = bit_valid;

	spw_ds_decoder #(
		.disc_cycles (disc_cycles)
	) u_spw_ds_decoder (
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.rx_din      (rx_din),
		.rx_sin      (rx_sin),
		.bit_valid   (bit_valid),
		.bit_value   (bit_value),
		.disconnect  (rx_disconnect)
	);

	spw_char_assembler u_spw_char_assembler (
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.bit_valid   (bit_valid),
		.bit_value   (bit_value),
		.char_start  (char_start),
		.char_word   (char_word),
		.parity_ok   (parity_ok)
	);

	spw_rx_control u_spw_rx_control (
		.negedge_clk    (negedge_clk),
		.rx_resetn      (rx_resetn),
		.bit_valid      (bit_valid),
		.bit_value      (bit_value),
		.parity_ok      (parity_ok),
		.disconnect     (rx_disconnect),
		.esc_error      (esc_error),
		.char_start     (char_start),
		.char_done      (char_done),
		.is_control     (is_control),
		.halt           (halt),
		.rx_error       (rx_error),
		.rx_error_cause (rx_error_cause)
	);

	spw_code_decoder u_spw_code_decoder (
		.negedge_clk      (negedge_clk),
		.rx_resetn        (rx_resetn),
		.char_done        (char_done),
		.is_control       (is_control),
		.halt             (halt),
		.char_word        (char_word),
		.rx_got_fct       (rx_got_fct),
		.rx_got_null      (rx_got_null),
		.rx_got_nchar     (rx_got_nchar),
		.rx_got_time_code (rx_got_time_code),
		.rx_data_flag     (rx_data_flag),
		.rx_buffer_write  (rx_buffer_write),
		.rx_time_out      (rx_time_out),
		.rx_tick_out      (rx_tick_out),
		.esc_error        (esc_error)
	);

endmodule

/* verif/spw_rx_checker.sv */
// Receiver output monitor: event queue, strobe, value and bit count compare, error checks

`timescale 1ns/10ps

module spw_rx_checker (
	input  logic                                     negedge_clk,
	input  logic                                     rx_resetn,
	input  logic                                     exp_push,
	input  logic [1:0]                               exp_kind,
	input  logic [8:0]                               exp_value,
	input  logic [spw_rx_status_pkg::cause_width-1:0] exp_cause,
	input  int                                       bits_sent,
	input  logic                                     rx_got_bit,
	input  logic                                     rx_got_fct,
	input  logic                                     rx_got_null,
	input  logic                                     rx_got_nchar,
	input  logic                                     rx_got_time_code,
	input  logic [8:0]                               rx_data_flag,
	input  logic                                     rx_buffer_write,
	input  logic [7:0]                               rx_time_out,
	input  logic                                     rx_tick_out,
	input  logic                                     rx_error,
	input  logic [spw_rx_status_pkg::cause_width-1:0] rx_error_cause,
	input  logic                                     rx_disconnect,
	output int                                       pending,
	output int                                       errors
);

	// Entry is {kind, value}, kinds 0 FCT, 1 NULL, 2 buffer write, 3 time code
	logic [10:0]                               exp_q[$];
	logic [10:0]                               head;
	logic                                      push_q;
	logic [10:0]                               entry_q;
	logic [spw_rx_status_pkg::cause_width-1:0] cause_q;
	logic                                      live;
	int                                        sent_q;
	int                                        bits_seen = 0;
	logic [5:0]                                got_strobes;
	logic [5:0]                                exp_strobes;
	logic                                      err_seen = 1'b0;
	logic                                      disc_seen = 1'b0;
	int                                        err_cnt = 0;

	// Strobe order is fct, null, nchar, buffer write, time code, tick
	function automatic logic [5:0] strobes_for(input logic [1:0] kind);
		case (kind)
			2'd0: return 6'b100000;
			2'd1: return 6'b010000;
			2'd2: return 6'b001100;
			default: return 6'b000011;
		endcase
	endfunction

	function automatic string strobe_name(input int idx);
		case (idx)
			5: return "rx_got_fct";
			4: return "rx_got_null";
			3: return "rx_got_nchar";
			2: return "rx_buffer_write";
			1: return "rx_got_time_code";
			default: return "rx_tick_out";
		endcase
	endfunction

	// Testbench side inputs change on the falling edge
	always @(posedge negedge_clk)
	begin
		push_q  <= exp_push;
		entry_q <= {exp_kind, exp_value};
		cause_q <= exp_cause;
		sent_q  <= bits_sent;
		live    <= rx_resetn;
		pending <= exp_q.size() + sent_q - bits_seen;
		errors  <= err_cnt;
	end

	// ----------------------------------------
	// Compare on the falling edge
	// ----------------------------------------
	always @(negedge negedge_clk)
	begin
		if (!live)
		begin
			exp_q.delete();
			bits_seen = 0;
			err_seen  = 1'b0;
			disc_seen = 1'b0;
		end
		else
		begin
			if (push_q)
				exp_q.push_back(entry_q);
			// One recovered bit per bit put on the lines
			if (rx_got_bit)
			begin
				if (bits_seen >= sent_q)
				begin
					$display("rx_got_bit pulsed although no bit was sent");
					err_cnt++;
				end
				else
					bits_seen++;
			end
			got_strobes = {rx_got_fct, rx_got_null, rx_got_nchar, rx_buffer_write,
				rx_got_time_code, rx_tick_out};
			if (got_strobes != 6'd0 && exp_q.size() == 0)
			begin
				$display("A strobe pulsed while no event was pending");
				err_cnt++;
			end
			else if (got_strobes != 6'd0)
			begin
				head        = exp_q.pop_front();
				exp_strobes = strobes_for(head[10:9]);
				if (got_strobes != exp_strobes)
				begin
					for (int i = 0; i < 6; i++)
					begin
						if (got_strobes[i] != exp_strobes[i])
							$display("FAIL %s exp=%h got=%h", strobe_name(i),
								exp_strobes[i], got_strobes[i]);
					end
					err_cnt++;
				end
				else if (head[10:9] == 2'd2 && rx_data_flag != head[8:0])
				begin
					$display("FAIL rx_data_flag exp=%h got=%h", head[8:0], rx_data_flag);
					err_cnt++;
				end
				else if (head[10:9] == 2'd3 && rx_time_out != head[7:0])
				begin
					$display("FAIL rx_time_out exp=%h got=%h", head[7:0], rx_time_out);
					err_cnt++;
				end
			end
			// Error and disconnect are only legal when a cause is expected
			if (rx_error && !err_seen)
			begin
				err_seen = 1'b1;
				if (cause_q == spw_rx_status_pkg::err_cause_none)
				begin
					$display("rx_error went high although no error was expected");
					err_cnt++;
				end
				else if (rx_error_cause != cause_q)
				begin
					$display("FAIL rx_error_cause exp=%h got=%h", cause_q, rx_error_cause);
					err_cnt++;
				end
			end
			if (rx_disconnect && !disc_seen && cause_q == spw_rx_status_pkg::err_cause_none)
			begin
				disc_seen = 1'b1;
				$display("rx_disconnect went high although the link was never active");
				err_cnt++;
			end
		end
	end

endmodule

/* verif/tb_spw_rx.sv */
// Receiver testbench: clock, reset, data-strobe encoding model with random stimulus, test sequence

`timescale 1ns/10ps

module tb_spw_rx;

	localparam int disc_cycles = 32;
	localparam int bit_clocks  = 6;

	logic       negedge_clk;
	logic       rx_resetn;
	logic       rx_din;
	logic       rx_sin;
	logic       exp_push;
	logic [1:0] exp_kind;
	logic [8:0] exp_value;
	logic [1:0] exp_cause;
	logic       rx_got_bit;
	logic       rx_got_fct;
	logic       rx_got_null;
	logic       rx_got_nchar;
	logic       rx_got_time_code;
	logic [8:0] rx_data_flag;
	logic       rx_buffer_write;
	logic [7:0] rx_time_out;
	logic       rx_tick_out;
	logic       rx_error;
	logic [1:0] rx_error_cause;
	logic       rx_disconnect;
	int         pending;
	int         errors;

	integer      seed;
	logic [31:0] rnd;
	logic        prev_par;
	int          bits_sent;
	int          tb_errors;
	int          last_errors;
	int          tests_run;
	int          tests_failed;

	spw_rx_top #(
		.disc_cycles (disc_cycles)
	) u_spw_rx_top (
		.negedge_clk      (negedge_clk),
		.rx_resetn        (rx_resetn),
		.rx_din           (rx_din),
		.rx_sin           (rx_sin),
		.rx_got_bit       (rx_got_bit),
		.rx_got_fct       (rx_got_fct),
		.rx_got_null      (rx_got_null),
		.rx_got_nchar     (rx_got_nchar),
		.rx_got_time_code (rx_got_time_code),
		.rx_data_flag     (rx_data_flag),
		.rx_buffer_write  (rx_buffer_write),
		.rx_time_out      (rx_time_out),
		.rx_tick_out      (rx_tick_out),
		.rx_error         (rx_error),
		.rx_error_cause   (rx_error_cause),
		.rx_disconnect    (rx_disconnect)
	);

	spw_rx_checker u_spw_rx_checker (
		.negedge_clk      (negedge_clk),
		.rx_resetn        (rx_resetn),
		.exp_push         (exp_push),
		.exp_kind         (exp_kind),
		.exp_value        (exp_value),
		.exp_cause        (exp_cause),
		.bits_sent        (bits_sent),
		.rx_got_bit       (rx_got_bit),
		.rx_got_fct       (rx_got_fct),
		.rx_got_null      (rx_got_null),
		.rx_got_nchar     (rx_got_nchar),
		.rx_got_time_code (rx_got_time_code),
		.rx_data_flag     (rx_data_flag),
		.rx_buffer_write  (rx_buffer_write),
		.rx_time_out      (rx_time_out),
		.rx_tick_out      (rx_tick_out),
		.rx_error         (rx_error),
		.rx_error_cause   (rx_error_cause),
		.rx_disconnect    (rx_disconnect),
		.pending          (pending),
		.errors           (errors)
	);

	initial
	begin
		negedge_clk = 1'b0;
		forever #2 negedge_clk = ~negedge_clk;
	end

	// ----------------------------------------
	// Encoding model
	// ----------------------------------------
	task automatic apply_reset(input logic [1:0] cause);
		rx_resetn = 1'b0;
		rx_din    = 1'b0;
		rx_sin    = 1'b0;
		exp_push  = 1'b0;
		exp_cause = cause;
		prev_par  = 1'b0;
		bits_sent = 0;
		repeat (3) @(negedge negedge_clk);
		rx_resetn = 1'b1;
		repeat (2) @(negedge negedge_clk);
	endtask

	// Strobe toggles when the data bit repeats
	task automatic send_bit(input logic b);
		if (b == rx_din)
			rx_sin = ~rx_sin;
		else
			rx_din = b;
		bits_sent++;
		repeat (bit_clocks) @(negedge negedge_clk);
	endtask

	// Odd sum over previous payload, parity bit and flag
	task automatic send_char(input logic ctrl, input logic [7:0] payload, input logic corrupt);
		int   n;
		logic par;
		n   = ctrl ? 2 : 8;
		par = ~(prev_par ^ ctrl) ^ corrupt;
		send_bit(par);
		send_bit(ctrl);
		prev_par = 1'b0;
		for (int i = 0; i < n; i++)
		begin
			send_bit(payload[i]);
			prev_par = prev_par ^ payload[i];
		end
	endtask

	task automatic expect_event(input logic [1:0] kind, input logic [8:0] value);
		exp_push  = 1'b1;
		exp_kind  = kind;
		exp_value = value;
		@(negedge negedge_clk);
		exp_push = 1'b0;
	endtask

	task automatic send_null();
		expect_event(2'd1, 9'd0);
		send_char(1'b1, 8'(spw_char_pkg::code_esc), 1'b0);
		send_char(1'b1, 8'(spw_char_pkg::code_fct), 1'b0);
	endtask

	task automatic send_fct();
		expect_event(2'd0, 9'd0);
		send_char(1'b1, 8'(spw_char_pkg::code_fct), 1'b0);
	endtask

	task automatic send_data(input logic [7:0] b);
		expect_event(2'd2, {1'b0, b});
		send_char(1'b0, b, 1'b0);
	endtask

	// Packet end, EOP is buffer word 256 and EEP is 257
	task automatic send_packet_end(input logic eep);
		expect_event(2'd2, eep ? spw_char_pkg::flag_eep : spw_char_pkg::flag_eop);
		send_char(1'b1, eep ? 8'(spw_char_pkg::code_eep) : 8'(spw_char_pkg::code_eop), 1'b0);
	endtask

	task automatic send_time(input logic [7:0] b);
		expect_event(2'd3, {1'b0, b});
		send_char(1'b1, 8'(spw_char_pkg::code_esc), 1'b0);
		send_char(1'b0, b, 1'b0);
	endtask

	// ----------------------------------------
	// Waits and reporting
	// ----------------------------------------
	task automatic wait_drain(input int limit);
		int cnt;
		cnt = 0;
		while (pending != 0 && cnt < limit)
		begin
			@(negedge negedge_clk);
			cnt++;
		end
		if (pending != 0)
		begin
			$display("Timed out with %0d expected events or bits never seen", pending);
			tb_errors++;
		end
	endtask

	task automatic wait_high(input logic disc, input int limit);
		int cnt;
		cnt = 0;
		while (!(disc ? rx_disconnect : rx_error) && cnt < limit)
		begin
			@(negedge negedge_clk);
			cnt++;
		end
		if (!(disc ? rx_disconnect : rx_error))
		begin
			$display("Timed out waiting for %s to go high", disc ? "rx_disconnect" : "rx_error");
			tb_errors++;
		end
	endtask

	task automatic end_test(input string name);
		int now_errors;
		repeat (4) @(negedge negedge_clk);
		now_errors = errors + tb_errors;
		tests_run++;
		if (now_errors == last_errors)
			$display("Test %0d %s: passed", tests_run, name);
		else
		begin
			tests_failed++;
			$display("Test %0d %s: failed", tests_run, name);
		end
		last_errors = now_errors;
	endtask

	initial
	begin
		seed         = 34;
		tb_errors    = 0;
		last_errors  = 0;
		tests_run    = 0;
		tests_failed = 0;
		exp_kind     = 2'd0;
		exp_value    = 9'd0;
		apply_reset(spw_rx_status_pkg::err_cause_none);
		for (int i = 0; i < 10; i++)
			send_null();
		wait_drain(100);
		end_test("ten NULLs");

		apply_reset(spw_rx_status_pkg::err_cause_none);
		repeat (3) send_null();
		for (int i = 0; i < 50; i++)
		begin
			rnd = $random(seed);
			send_data(rnd[7:0]);
		end
		wait_drain(100);
		end_test("random data bytes");

		// Mixed FCT, EOP, EEP and data
		apply_reset(spw_rx_status_pkg::err_cause_none);
		send_null();
		for (int i = 0; i < 40; i++)
		begin
			rnd = $random(seed);
			case (rnd[9:8])
				2'd0: send_fct();
				2'd1: send_packet_end(1'b0);
				2'd2: send_packet_end(1'b1);
				default: send_data(rnd[7:0]);
			endcase
		end
		wait_drain(100);
		end_test("mixed control and data");

		apply_reset(spw_rx_status_pkg::err_cause_none);
		send_null();
		for (int i = 0; i < 20; i++)
		begin
			rnd = $random(seed);
			send_time(rnd[7:0]);
		end
		wait_drain(100);
		end_test("random time codes");

		// Bad parity, then traffic that must be ignored
		apply_reset(spw_rx_status_pkg::err_cause_parity);
		repeat (2) send_null();
		rnd = $random(seed);
		send_char(1'b0, rnd[7:0], 1'b1);
		wait_high(1'b0, 40);
		send_char(1'b0, rnd[15:8], 1'b0);
		send_char(1'b1, 8'(spw_char_pkg::code_fct), 1'b0);
		wait_drain(100);
		end_test("parity error");

		apply_reset(spw_rx_status_pkg::err_cause_escape);
		send_null();
		send_char(1'b1, 8'(spw_char_pkg::code_esc), 1'b0);
		send_char(1'b1, 8'(spw_char_pkg::code_eop), 1'b0);
		wait_high(1'b0, 20);
		send_char(1'b0, 8'h5a, 1'b0);
		wait_drain(100);
		end_test("escape then EOP");

		apply_reset(spw_rx_status_pkg::err_cause_disconnect);
		repeat (2) send_null();
		wait_drain(100);
		wait_high(1'b1, disc_cycles + 10);
		wait_high(1'b0, 10);
		end_test("disconnect after traffic");

		// Quiet lines straight after reset
		apply_reset(spw_rx_status_pkg::err_cause_none);
		repeat (disc_cycles * 3) @(negedge negedge_clk);
		end_test("idle after reset");

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			errors + tb_errors);
		if (tests_failed == 0 && errors + tb_errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
